//--- include/yolo_fixed.svh
`ifndef YOLO_FIXED_SVH
`define YOLO_FIXED_SVH

// width of the shift and b_shift fields
`define SHIFT_W 6

// sigmoid segment breakpoints, Q8.24 in the low bits of an accumulator
`define Q24_5_0     64'h0000_0000_0500_0000
`define Q24_2_375   64'h0000_0000_0260_0000
`define Q24_1_0     64'h0000_0000_0100_0000

// segment offsets
`define Q24_0_84375 64'h0000_0000_00D8_0000
`define Q24_0_625   64'h0000_0000_00A0_0000
`define Q24_0_5     64'h0000_0000_0080_0000

// segment slopes as right shifts (1/32, 1/8, 1/4)
`define SIG_SH_HI   5
`define SIG_SH_MID  3
`define SIG_SH_LO   2

`endif

//--- verilog/yolo_data_pkg.sv
package yolo_data_pkg;

   // operand width, fixed by the Q8.24 sigmoid constants
   localparam int DATAPATH_W = 32;

   // full-precision accumulator
   localparam int ACC_W = 2 * DATAPATH_W;

   // pixel, weight, bias and result word
   typedef logic signed [DATAPATH_W-1:0] operand_t;

   // lane product sums and everything up to the final shift
   typedef logic signed [ACC_W-1:0] acc_t;

endpackage

//--- verilog/yolo_cfg_pkg.sv
`include "yolo_fixed.svh"

package yolo_cfg_pkg;

   localparam int CFG_WORD_W = 32;
   localparam int CFG_ADDR_W = 2;

   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

   // register map
   localparam cfg_addr_t CFG_ADDR_MODE  = 2'd0;
   localparam cfg_addr_t CFG_ADDR_SHIFT = 2'd1;

   // mode word, flags in the low bits
   typedef struct packed {
      logic [CFG_WORD_W-7:0] pad;
      logic                  bias_en;
      logic                  leaky;
      logic                  sigmoid;
      logic                  maxpool;
      logic                  bypass;
      logic                  bypass_adder;
   } layer_mode_t;

   // shift word, b_shift above shift
   typedef struct packed {
      logic [CFG_WORD_W-2*`SHIFT_W-1:0] pad;
      logic [`SHIFT_W-1:0]              b_shift;
      logic [`SHIFT_W-1:0]              shift;
   } layer_shift_t;

   // one write word, read as mode or shift depending on address
   typedef union packed {
      layer_mode_t  mode;
      layer_shift_t shamt;
   } layer_cfg_word_u;

   // full layer configuration seen by the datapath
   typedef struct packed {
      layer_mode_t  mode;
      layer_shift_t shamt;
   } layer_cfg_t;

endpackage

//--- verilog/mac_pipe.sv
`timescale 1ns/100ps

module mac_pipe (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 ld_acc,
   input  yolo_data_pkg::operand_t in_a,
   input  yolo_data_pkg::operand_t in_b,
   input  yolo_data_pkg::acc_t     in_c,
   output yolo_data_pkg::acc_t     acc_out
);

   import yolo_data_pkg::*;

   operand_t a_r, b_r;
   acc_t     c_r1, c_r2, c_r3;
   acc_t     prod_r1, prod_r2;
   logic     ld_r1, ld_r2, ld_r3;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         a_r     <= '0;
         b_r     <= '0;
         c_r1    <= '0;
         c_r2    <= '0;
         c_r3    <= '0;
         prod_r1 <= '0;
         prod_r2 <= '0;
         ld_r1   <= 1'b0;
         ld_r2   <= 1'b0;
         ld_r3   <= 1'b0;
         acc_out <= '0;
      end else begin
         // stage 1 input registers
         a_r   <= in_a;
         b_r   <= in_b;
         c_r1  <= in_c;
         ld_r1 <= ld_acc;
         // stages 2 and 3 multiply, preload and load flag follow along
         prod_r1 <= acc_t'(a_r) * acc_t'(b_r);
         prod_r2 <= prod_r1;
         c_r2    <= c_r1;
         c_r3    <= c_r2;
         ld_r2   <= ld_r1;
         ld_r3   <= ld_r2;
         // stage 4 accumulate, restart from preload on a new window
         acc_out <= (ld_r3 ? c_r3 : acc_out) + prod_r2;
      end
   end

endmodule

//--- verilog/adder_tree.sv
`timescale 1ns/100ps

module adder_tree #(
   parameter int N_INPUTS = 4
) (
   input  logic                                clk,
   input  logic                                rst,
   input  yolo_data_pkg::acc_t [N_INPUTS-1:0] data_in,
   output yolo_data_pkg::acc_t                 data_out
);

   import yolo_data_pkg::*;

   acc_t sum;

   // running sum over all lanes
   always_comb begin
      sum = '0;
      for (int i = 0; i < N_INPUTS; i++) begin
         sum = sum + data_in[i];
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         data_out <= '0;
      end else begin
         data_out <= sum;
      end
   end

endmodule

//--- verilog/layer_cfg_regs.sv
`timescale 1ns/100ps

module layer_cfg_regs (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cfg_we,
   input  yolo_cfg_pkg::cfg_addr_t       cfg_addr,
   input  yolo_cfg_pkg::layer_cfg_word_u cfg_wdata,
   output yolo_cfg_pkg::layer_cfg_t      cfg
);

   import yolo_cfg_pkg::*;

   layer_mode_t  mode_r;
   layer_shift_t shift_r;

   // the address picks which view of the write word is taken
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         mode_r  <= '0;
         shift_r <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            CFG_ADDR_MODE: begin
               mode_r <= cfg_wdata.mode;
            end
            CFG_ADDR_SHIFT: begin
               shift_r <= cfg_wdata.shamt;
            end
            default: begin
               // unmapped, write dropped
               mode_r <= mode_r;
            end
         endcase
      end
   end

   assign cfg = '{mode: mode_r, shamt: shift_r};

endmodule

//--- verilog/xyolo.sv
`timescale 1ns/100ps

`include "yolo_fixed.svh"

module xyolo #(
   parameter int  N_MACS = 4,
   localparam int NMAC_W = (N_MACS > 1) ? $clog2(N_MACS) : 1
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  ld_acc,
   input  logic                                  ld_mp,
   input  logic                                  ld_res,
   input  logic [NMAC_W-1:0]                     ld_nmac,
   input  yolo_cfg_pkg::layer_cfg_t              cfg,
   input  yolo_data_pkg::operand_t [N_MACS-1:0]  pixels,
   input  yolo_data_pkg::operand_t [N_MACS-1:0]  weights,
   input  yolo_data_pkg::operand_t               bias_in,
   output yolo_data_pkg::operand_t               flow_out
);

   import yolo_data_pkg::*;

   logic [`SHIFT_W-1:0] shift, b_shift;
   acc_t [N_MACS-1:0]   lane_c, lane_acc;
   acc_t                bias_shifted, conv_res, conv_r, conv_r2;
   acc_t                leaky_neg, leaky_out, leaky_r1, leaky_r2;
   logic [ACC_W-1:0]    sig_in;
   acc_t                sig_t1, sig_t2, sig_t1_r, sig_t2_r, sig_sum, sig_out, sig_out_r;
   acc_t                act_sel, act_shifted, raw_shifted;
   operand_t            act_r, byp_pix, byp_pix_r, cand, pooled, result_d, result;

   assign shift   = cfg.shamt.shift;
   assign b_shift = cfg.shamt.b_shift;

   // bias goes into the upper half, then scaled down
   assign bias_shifted = acc_t'({bias_in, {DATAPATH_W{1'b0}}}) >>> b_shift;

   for (genvar i = 0; i < N_MACS; i++) begin : g_lane
      if (i == 0) begin : g_bias
         assign lane_c[i] = cfg.mode.bias_en ? bias_shifted : '0;
      end else begin : g_zero
         assign lane_c[i] = '0;
      end
      mac_pipe u_mac (
         .clk     (clk),
         .rst     (rst),
         .ld_acc  (ld_acc),
         .in_a    (pixels[i]),
         .in_b    (weights[i]),
         .in_c    (lane_c[i]),
         .acc_out (lane_acc[i])
      );
   end

   adder_tree #(.N_INPUTS(N_MACS)) u_adder (
      .clk      (clk),
      .rst      (rst),
      .data_in  (lane_acc),
      .data_out (conv_res)
   );

   // leaky, x * (1/16 + 1/32 + 1/128) ~ 0.1 for negatives
   assign leaky_neg = (conv_res >>> 4) + (conv_res >>> 5) + (conv_res >>> 7);
   assign leaky_out = conv_res[ACC_W-1] ? leaky_neg : conv_res;

   // sigmoid on |x|, four linear segments
   assign sig_in = conv_res[ACC_W-1] ? -conv_res : conv_res;

   always_comb begin
      if (sig_in >= `Q24_5_0) begin
         sig_t1 = `Q24_1_0;
         sig_t2 = '0;
      end else if (sig_in >= `Q24_2_375) begin
         sig_t1 = `Q24_0_84375;
         sig_t2 = acc_t'(sig_in >> `SIG_SH_HI);
      end else if (sig_in >= `Q24_1_0) begin
         sig_t1 = `Q24_0_625;
         sig_t2 = acc_t'(sig_in >> `SIG_SH_MID);
      end else begin
         sig_t1 = `Q24_0_5;
         sig_t2 = acc_t'(sig_in >> `SIG_SH_LO);
      end
   end

   // mirror for negative sums, sign taken from the delayed sum
   assign sig_sum = sig_t1_r + sig_t2_r;
   assign sig_out = conv_r[ACC_W-1] ? acc_t'(`Q24_1_0) - sig_sum : sig_sum;

   assign act_sel = cfg.mode.leaky ? leaky_r2 :
                    cfg.mode.sigmoid ? sig_out_r : conv_r2;
   assign act_shifted = act_sel >>> shift;

   // pixel for bypass
   always_comb begin
      byp_pix = pixels[0];
      for (int k = 0; k < N_MACS; k++) begin
         if (k == int'(ld_nmac)) begin
            byp_pix = pixels[k];
         end
      end
   end

   // raw lane 0 output, logical shift
   assign raw_shifted = lane_acc[0] >> shift;

   assign cand     = cfg.mode.bypass ? byp_pix_r : act_r;
   assign pooled   = (ld_mp && result > cand) ? result : cand;
   assign result_d = cfg.mode.bypass_adder ? raw_shifted[DATAPATH_W-1:0] :
                     cfg.mode.maxpool ? pooled : cand;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         conv_r    <= '0;
         conv_r2   <= '0;
         leaky_r1  <= '0;
         leaky_r2  <= '0;
         sig_t1_r  <= '0;
         sig_t2_r  <= '0;
         sig_out_r <= '0;
         act_r     <= '0;
         byp_pix_r <= '0;
         result    <= '0;
      end else begin
         // two activation stages, all paths aligned
         conv_r    <= conv_res;
         conv_r2   <= conv_r;
         leaky_r1  <= leaky_out;
         leaky_r2  <= leaky_r1;
         sig_t1_r  <= sig_t1;
         sig_t2_r  <= sig_t2;
         sig_out_r <= sig_out;
         act_r     <= act_shifted[DATAPATH_W-1:0];
         byp_pix_r <= byp_pix;
         if (ld_res) begin
            result <= result_d;
         end
      end
   end

   assign flow_out = result;

endmodule

//--- verilog/yolo_unit_top.sv
`timescale 1ns/100ps

module yolo_unit_top #(
   parameter int  N_MACS = 4,
   localparam int NMAC_W = (N_MACS > 1) ? $clog2(N_MACS) : 1
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cfg_we,
   input  yolo_cfg_pkg::cfg_addr_t               cfg_addr,
   input  yolo_cfg_pkg::layer_cfg_word_u         cfg_wdata,
   input  logic                                  ld_acc,
   input  logic                                  ld_mp,
   input  logic                                  ld_res,
   input  logic [NMAC_W-1:0]                     ld_nmac,
   input  yolo_data_pkg::operand_t [N_MACS-1:0]  pixels,
   input  yolo_data_pkg::operand_t [N_MACS-1:0]  weights,
   input  yolo_data_pkg::operand_t               bias_in,
   output yolo_data_pkg::operand_t               flow_out
);

   import yolo_cfg_pkg::*;

   layer_cfg_t cfg;

   layer_cfg_regs u_cfg (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg)
   );

   // compute unit
   xyolo #(.N_MACS(N_MACS)) u_xyolo (
      .clk      (clk),
      .rst      (rst),
      .ld_acc   (ld_acc),
      .ld_mp    (ld_mp),
      .ld_res   (ld_res),
      .ld_nmac  (ld_nmac),
      .cfg      (cfg),
      .pixels   (pixels),
      .weights  (weights),
      .bias_in  (bias_in),
      .flow_out (flow_out)
   );

endmodule

//--- tb/yolo_unit_monitor.sv
`timescale 1ns/100ps

`include "yolo_fixed.svh"

module yolo_unit_monitor #(
   parameter int  N_MACS = 4,
   localparam int NMAC_W = (N_MACS > 1) ? $clog2(N_MACS) : 1
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 cfg_we,
   input  yolo_cfg_pkg::cfg_addr_t              cfg_addr,
   input  yolo_cfg_pkg::layer_cfg_word_u        cfg_wdata,
   input  logic                                 ld_acc,
   input  logic                                 ld_mp,
   input  logic                                 ld_res,
   input  logic [NMAC_W-1:0]                    ld_nmac,
   input  yolo_data_pkg::operand_t [N_MACS-1:0] pixels,
   input  yolo_data_pkg::operand_t [N_MACS-1:0] weights,
   input  yolo_data_pkg::operand_t              bias_in,
   input  yolo_data_pkg::operand_t              flow_out,
   output int                                   errors,
   output int                                   checks
);

   import yolo_data_pkg::*;
   import yolo_cfg_pkg::*;

   layer_mode_t  mode_m;
   layer_shift_t shift_m;
   acc_t         lane_sum [N_MACS];
   operand_t     exp_res;
   operand_t     pix_prev;

   // four linear segments on |x|, mirrored below zero
   function automatic acc_t sigmoid_ref(input acc_t s);
      acc_t a;
      acc_t y;
      a = (s < 0) ? -s : s;
      if (a >= `Q24_5_0)
         y = `Q24_1_0;
      else if (a >= `Q24_2_375)
         y = `Q24_0_84375 + a / 32;
      else if (a >= `Q24_1_0)
         y = `Q24_0_625 + a / 8;
      else
         y = `Q24_0_5 + a / 4;
      if (s < 0)
         y = `Q24_1_0 - y;
      return y;
   endfunction

   function automatic operand_t next_result();
      acc_t     total;
      acc_t     act;
      acc_t     raw;
      operand_t cand;
      total = '0;
      for (int i = 0; i < N_MACS; i++)
         total = total + lane_sum[i];
      if (mode_m.leaky)
         act = (total < 0) ? (total >>> 4) + (total >>> 5) + (total >>> 7) : total;
      else if (mode_m.sigmoid)
         act = sigmoid_ref(total);
      else
         act = total;
      act  = act >>> shift_m.shift;
      cand = mode_m.bypass ? pix_prev : operand_t'(act[DATAPATH_W-1:0]);
      raw  = lane_sum[0] >> shift_m.shift;
      if (mode_m.bypass_adder)
         return operand_t'(raw[DATAPATH_W-1:0]);
      if (mode_m.maxpool && ld_mp && exp_res > cand)
         return exp_res;
      return cand;
   endfunction

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         mode_m   = '0;
         shift_m  = '0;
         exp_res  = '0;
         pix_prev = '0;
         errors   = 0;
         checks   = 0;
         for (int i = 0; i < N_MACS; i++)
            lane_sum[i] = '0;
      end else begin
         checks++;
         if (flow_out !== exp_res) begin
            errors++;
            $display("** Error at %0t ns: flow_out expected %0d, actual %0d",
                     $time, exp_res, flow_out);
         end
         if (ld_res)
            exp_res = next_result();
         // lane sums without the pipeline delay
         for (int i = 0; i < N_MACS; i++) begin
            acc_t pre;
            pre = '0;
            if (i == 0 && mode_m.bias_en)
               pre = acc_t'({bias_in, {DATAPATH_W{1'b0}}}) >>> shift_m.b_shift;
            lane_sum[i] = (ld_acc ? pre : lane_sum[i]) + acc_t'(pixels[i]) * acc_t'(weights[i]);
         end
         pix_prev = pixels[ld_nmac];
         if (cfg_we && cfg_addr == CFG_ADDR_MODE)
            mode_m = cfg_wdata.mode;
         else if (cfg_we && cfg_addr == CFG_ADDR_SHIFT)
            shift_m = cfg_wdata.shamt;
      end
   end

endmodule

//--- tb/yolo_unit_checker.sv
`timescale 1ns/100ps

module yolo_unit_checker (
   input logic                    clk,
   input logic                    rst,
   input logic                    cfg_we,
   input logic                    ld_res,
   input yolo_data_pkg::operand_t flow_out
);

   // number of failed assertions
   int fails = 0;

   // configuration strobe is a single-cycle pulse
   a_we_single : assert property (@(posedge clk) disable iff (rst) cfg_we |=> !cfg_we)
      else begin
         fails++;
         $error("cfg_we stayed high for two cycles");
      end

   a_res_in_reset : assert property (@(posedge clk) rst |-> !ld_res)
      else begin
         fails++;
         $error("ld_res was raised while reset was active");
      end

   // result register only moves after an ld_res pulse
   a_out_stable : assert property (@(posedge clk) disable iff (rst)
      !$past(ld_res) |-> $stable(flow_out))
      else begin
         fails++;
         $error("flow_out changed without an ld_res pulse");
      end

endmodule

bind yolo_unit_top yolo_unit_checker u_checker (.*);

//--- tb/tb_yolo_unit.sv
`timescale 1ns/100ps

module tb_yolo_unit;

   import yolo_data_pkg::*;
   import yolo_cfg_pkg::*;

   localparam int          N_MACS        = 4;
   localparam int          NUM_CASES     = 20;
   localparam int          CASE_OVERHEAD = 20;
   localparam logic [31:0] SEED          = 32'd43558;

   typedef struct packed {
      logic [31:0] mode_w;
      logic [31:0] shift_w;
      logic [7:0]  len;
      logic        mp;
      logic [1:0]  nmac;
      logic [31:0] bias;
      logic [31:0] seed_off;
   } case_t;

   logic clk, rst, cfg_we, ld_acc, ld_mp, ld_res;
   logic [1:0] ld_nmac;
   cfg_addr_t cfg_addr;
   layer_cfg_word_u cfg_wdata;
   operand_t [N_MACS-1:0] pixels, weights;
   operand_t bias_in, flow_out;
   int errors, checks, cycles, limit;
   logic [31:0] rng;
   case_t cases [NUM_CASES];

   yolo_unit_top #(.N_MACS(N_MACS)) dut (.*);

   yolo_unit_monitor #(.N_MACS(N_MACS)) monitor (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] mode_word(input logic b, l, s, p, y, a);
      layer_mode_t m;
      m = '0;
      m.bias_en = b;
      m.leaky = l;
      m.sigmoid = s;
      m.maxpool = p;
      m.bypass = y;
      m.bypass_adder = a;
      return m;
   endfunction

   function automatic logic [31:0] shift_word(input logic [5:0] b_sh, sh);
      layer_shift_t w;
      w = '0;
      w.b_shift = b_sh;
      w.shift = sh;
      return w;
   endfunction

   // one operand pair per lane with weights zero when idle
   task automatic drive_lanes(input logic active);
      operand_t [N_MACS-1:0] p, w;
      for (int i = 0; i < N_MACS; i++) begin
         rng = xorshift(rng);
         p[i] = operand_t'($signed(rng[7:0]));
         rng = xorshift(rng);
         w[i] = active ? operand_t'($signed(rng[7:0])) : '0;
      end
      pixels <= p;
      weights <= w;
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input logic [31:0] data);
      @(posedge clk);
      cfg_we <= 1'b1;
      cfg_addr <= addr;
      cfg_wdata <= data;
      @(posedge clk);
      cfg_we <= 1'b0;
   endtask

   task automatic run_case(input case_t c);
      write_cfg(CFG_ADDR_MODE, c.mode_w);
      write_cfg(CFG_ADDR_SHIFT, c.shift_w);
      // address 3 is unmapped and must not change anything
      write_cfg(2'd3, ~c.mode_w);
      rng = SEED + c.seed_off;
      bias_in <= c.bias;
      ld_nmac <= c.nmac;
      for (int i = 0; i < int'(c.len); i++) begin
         @(posedge clk);
         drive_lanes(1'b1);
         ld_acc <= (i == 0);
      end
      repeat (7) begin
         @(posedge clk);
         drive_lanes(1'b0);
         ld_acc <= 1'b0;
      end
      @(posedge clk);
      drive_lanes(1'b0);
      ld_res <= 1'b1;
      ld_mp <= c.mp;
      @(posedge clk);
      drive_lanes(1'b0);
      ld_res <= 1'b0;
      ld_mp <= 1'b0;
      repeat (2) begin
         @(posedge clk);
         drive_lanes(1'b0);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles, a window never finished", cycles);
         $display("test failed");
         $finish;
      end
   end

   initial begin
      rst = 1'b1;
      cfg_we = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      ld_acc = 1'b0;
      ld_mp = 1'b0;
      ld_res = 1'b0;
      ld_nmac = '0;
      pixels = '0;
      weights = '0;
      bias_in = '0;
      cycles = 0;
      rng = SEED;
      // mode flag order is bias, leaky, sigmoid, maxpool, bypass, bypass_adder
      cases[0]  = '{mode_word(1,0,0,0,0,0), shift_word(20, 3), 6, 0, 0, 37, 1};
      cases[1]  = '{mode_word(0,0,0,0,0,0), shift_word(0, 0), 4, 0, 0, 0, 2};
      cases[2]  = '{mode_word(1,1,0,0,0,0), shift_word(8, 0), 5, 0, 0, -9, 3};
      cases[3]  = '{mode_word(1,1,0,0,0,0), shift_word(8, 1), 5, 0, 0, 9, 4};
      cases[4]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, 6, 5};
      cases[5]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, -6, 6};
      cases[6]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, 3, 7};
      cases[7]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, -3, 8};
      cases[8]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, 2, 9};
      cases[9]  = '{mode_word(1,0,1,0,0,0), shift_word(8, 8), 3, 0, 0, -2, 10};
      cases[10] = '{mode_word(1,0,1,0,0,0), shift_word(9, 4), 3, 0, 0, 1, 11};
      cases[11] = '{mode_word(1,0,1,0,0,0), shift_word(9, 4), 3, 0, 0, -1, 12};
      cases[12] = '{mode_word(0,0,0,1,0,0), shift_word(0, 0), 4, 0, 0, 0, 13};
      cases[13] = '{mode_word(0,0,0,1,0,0), shift_word(0, 0), 4, 1, 0, 0, 14};
      cases[14] = '{mode_word(0,0,0,1,0,0), shift_word(0, 0), 4, 1, 0, 0, 15};
      cases[15] = '{mode_word(0,0,0,1,0,0), shift_word(0, 0), 4, 1, 0, 0, 16};
      cases[16] = '{mode_word(0,0,0,0,1,0), shift_word(0, 0), 2, 0, 2, 0, 17};
      cases[17] = '{mode_word(0,0,0,0,1,0), shift_word(0, 0), 2, 0, 3, 0, 18};
      cases[18] = '{mode_word(1,0,0,0,0,1), shift_word(16, 2), 5, 0, 0, 21, 19};
      cases[19] = '{mode_word(0,0,0,0,0,1), shift_word(0, 1), 5, 0, 0, 0, 20};
      limit = 10 + 20;
      foreach (cases[i])
         limit += int'(cases[i].len) + CASE_OVERHEAD;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      foreach (cases[i])
         run_case(cases[i]);
      repeat (2) @(posedge clk);
      $display("checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, dut.u_checker.fails);
      if (errors == 0 && dut.u_checker.fails == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+include
verilog/yolo_data_pkg.sv
verilog/yolo_cfg_pkg.sv
verilog/mac_pipe.sv
verilog/adder_tree.sv
verilog/layer_cfg_regs.sv
verilog/xyolo.sv
verilog/yolo_unit_top.sv
tb/yolo_unit_monitor.sv
tb/yolo_unit_checker.sv
tb/tb_yolo_unit.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_yolo_unit
FILELIST = files.f
OBJ_DIR  = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) include/yolo_fixed.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
